//--- all.f
+incdir+tests
hw/vseq_pkg.sv
hw/vseq_if.sv
hw/vseq_decode.sv
hw/vseq_hazard_check.sv
hw/vseq_issue_ctrl.sv
hw/vseq_completion.sv
hw/vseq_top.sv
tests/tb_vseq.sv

//--- tests/tb_vseq_model.svh
`ifndef TB_VSEQ_MODEL_SVH
`define TB_VSEQ_MODEL_SVH

// Run length and random seed
localparam logic [31:0] lfsr_seed       = 32'h9abd;
localparam int unsigned n_tests         = 200;
// Cycle budget per instruction before the watchdog fires
localparam int unsigned cycles_per_test = 60;

logic [31:0] lfsr_q = lfsr_seed;

// DUT running set at the previous sample and the done bits seen there
hazard_vec_t        m_run  = '0;
hazard_vec_t        m_done = '0;
vfu_e               m_unit [n_vinsn];
hazard_vec_t        m_row  [n_vinsn];
// Last reader and last writer of every register
vid_t               rd_id [n_vregs];
vid_t               wr_id [n_vregs];
logic [n_vregs-1:0] rd_vld = '0;
logic [n_vregs-1:0] wr_vld = '0;
// Accepted but not yet issued, oldest first
dec_insn_t          pend_q [$];

//////////////////////////////
// Random bits
//////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(int unsigned n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    r      = {r[30:0], lfsr_q[0]};
  end
  return r;
endfunction

//////////////////////////////
// Reference model
//////////////////////////////

function automatic vfu_e unit_of(vop_e op);
  case (op)
    vadd, vsub, vand: return vfu_alu;
    vmul, vmacc:      return vfu_mul;
    vle:              return vfu_load;
    default:          return vfu_store;
  endcase
endfunction

function automatic dec_insn_t make_insn(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                                        logic use_vd, logic use_vs1, logic use_vs2,
                                        logic vm);
  dec_insn_t q;
  q.op      = op;
  q.vfu     = unit_of(op);
  q.is_mem  = (op == vle) || (op == vse);
  q.vd      = vd;
  q.vs1     = vs1;
  q.vs2     = vs2;
  q.use_vd  = use_vd;
  q.use_vs1 = use_vs1;
  q.use_vs2 = use_vs2;
  q.vm      = vm;
  return q;
endfunction

function automatic vid_t lowest_free(hazard_vec_t run);
  for (int i = 0; i < n_vinsn; i++) begin
    if (!run[i]) return vid_t'(i);
  end
  return '0;
endfunction

// RAW on sources and mask, WAR and WAW on the destination
function automatic hazard_vec_t expect_hazard(dec_insn_t q, hazard_vec_t run);
  hazard_vec_t h;
  h = '0;
  if (q.use_vs1 && wr_vld[q.vs1]) h[wr_id[q.vs1]] = 1'b1;
  if (q.use_vs2 && wr_vld[q.vs2]) h[wr_id[q.vs2]] = 1'b1;
  if (!q.vm && wr_vld[vmask_reg]) h[wr_id[vmask_reg]] = 1'b1;
  if (q.use_vd && rd_vld[q.vd]) h[rd_id[q.vd]] = 1'b1;
  if (q.use_vd && wr_vld[q.vd]) h[wr_id[q.vd]] = 1'b1;
  return h & run;
endfunction

function automatic void record_users(dec_insn_t q, vid_t id);
  if (q.use_vd) begin
    wr_id[q.vd]  = id;
    wr_vld[q.vd] = 1'b1;
  end
  if (q.use_vs1) begin
    rd_id[q.vs1]  = id;
    rd_vld[q.vs1] = 1'b1;
  end
  if (q.use_vs2) begin
    rd_id[q.vs2]  = id;
    rd_vld[q.vs2] = 1'b1;
  end
  if (!q.vm) begin
    rd_id[vmask_reg]  = id;
    rd_vld[vmask_reg] = 1'b1;
  end
endfunction

// Entries of finished IDs must not leak into a reused ID
function automatic void drop_retired(hazard_vec_t run);
  for (int v = 0; v < n_vregs; v++) begin
    rd_vld[v] = rd_vld[v] && run[rd_id[v]];
    wr_vld[v] = wr_vld[v] && run[wr_id[v]];
  end
endfunction

`endif

//--- tests/tb_vseq.sv
module tb_vseq;
  import vseq_pkg::*;

  `include "tb_vseq_model.svh"

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  logic        req_ready_o;
  vop_e        req_op_i;
  vreg_t       req_vd_i;
  vreg_t       req_vs1_i;
  vreg_t       req_vs2_i;
  logic        req_use_vd_i;
  logic        req_use_vs1_i;
  logic        req_use_vs2_i;
  logic        req_vm_i;
  logic        pe_req_valid_o;
  logic        pe_req_ready_i;
  vid_t        pe_req_id_o;
  vop_e        pe_req_op_o;
  vfu_e        pe_req_vfu_o;
  hazard_vec_t pe_req_hazard_o;
  hazard_vec_t vinsn_done_i;
  logic        addrgen_ack_i;
  logic        addrgen_error_i;
  logic        resp_valid_o;
  logic        resp_error_o;
  logic        idle_o;
  logic [n_vinsn*n_vinsn-1:0] hazard_table_o;

  // Responder state
  int unsigned done_tmr [n_vinsn] = '{default: 0};
  int unsigned ack_tmr   = 0;
  int unsigned n_acc     = 0;
  // Checker state
  int unsigned n_issued  = 0;
  int unsigned val_errs  = 0;
  int unsigned flow_errs = 0;
  logic        pv_prev   = 1'b0;
  logic        hs_prev   = 1'b0;
  logic        mem_wait  = 1'b0;
  logic        resp_due  = 1'b0;
  logic        resp_err_exp;
  vid_t        hold_id;
  vop_e        hold_op;
  vfu_e        hold_vfu;
  hazard_vec_t hold_h;

  vseq_top vseq_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_counts();
    $display("Summary: %0d value errors, %0d protocol errors, %0d of %0d issued",
             val_errs, flow_errs, n_issued, n_tests);
  endtask

  //////////////////////////////
  // Stimulus and responders
  //////////////////////////////

  always @(posedge clk_i) begin
    hazard_vec_t done_v;
    logic        taken;
    logic [2:0]  op_bits;
    if (rst_ni) begin
      // Request is held until the DUT takes it
      taken = req_valid_i && req_ready_o;
      if (taken) n_acc++;
      if (!req_valid_i || taken) begin
        if (n_acc < n_tests && take_bits(1) != 0) begin
          op_bits = take_bits(3);
          req_valid_i   <= 1'b1;
          req_op_i      <= (op_bits == 3'd7) ? vadd : vop_e'(op_bits);
          // Only v0..v7 to make hazards frequent
          req_vd_i      <= vreg_t'(take_bits(3));
          req_vs1_i     <= vreg_t'(take_bits(3));
          req_vs2_i     <= vreg_t'(take_bits(3));
          req_use_vd_i  <= take_bits(1) != 0;
          req_use_vs1_i <= take_bits(1) != 0;
          req_use_vs2_i <= take_bits(1) != 0;
          req_vm_i      <= take_bits(2) != 0;
        end else begin
          req_valid_i <= 1'b0;
        end
      end
      pe_req_ready_i <= take_bits(1) != 0;
      // Done bits come 1 to 32 cycles after the PE handshake
      done_v = '0;
      for (int i = 0; i < n_vinsn; i++) begin
        if (done_tmr[i] != 0) begin
          done_tmr[i]--;
          if (done_tmr[i] == 0) done_v[i] = 1'b1;
        end
      end
      if (pe_req_valid_o && pe_req_ready_i) done_tmr[pe_req_id_o] = 1 + take_bits(5);
      vinsn_done_i <= done_v;
      // Address ack for a handed-over load or store
      addrgen_ack_i <= 1'b0;
      if (ack_tmr != 0) begin
        ack_tmr--;
        if (ack_tmr == 0) begin
          addrgen_ack_i   <= 1'b1;
          addrgen_error_i <= take_bits(1) != 0;
        end
      end
      if (pe_req_valid_o && pe_req_ready_i &&
          (pe_req_vfu_o == vfu_load || pe_req_vfu_o == vfu_store)) begin
        ack_tmr = 1 + take_bits(3);
      end
    end
  end

  //////////////////////////////
  // Compare
  //////////////////////////////

  always @(posedge clk_i) begin
    dec_insn_t   q;
    hazard_vec_t exp_h;
    hazard_vec_t new_bit;
    vid_t        exp_id;
    logic        new_iss;
    int unsigned cnt;
    if (rst_ni) begin
      new_bit = '0;
      // Fresh request on the PE port that fired at the previous edge
      new_iss = pe_req_valid_o && (!pv_prev || hs_prev);
      if (req_valid_i && req_ready_o) begin
        pend_q.push_back(make_insn(req_op_i, req_vd_i, req_vs1_i, req_vs2_i, req_use_vd_i,
                                   req_use_vs1_i, req_use_vs2_i, req_vm_i));
      end
      if (new_iss) begin
        if (mem_wait) begin
          $display("Issue at %0t while a load or store still waited for its ack", $time);
          flow_errs++;
        end
        if (pend_q.size() == 0) begin
          $display("Issue at %0t without any accepted request behind it", $time);
          flow_errs++;
        end else begin
          q      = pend_q.pop_front();
          exp_id = lowest_free(m_run);
          exp_h  = expect_hazard(q, m_run);
          if (pe_req_id_o !== exp_id) begin
            $display("Error at %0t: issue ID %0d, expected %0d", $time, pe_req_id_o, exp_id);
            val_errs++;
          end
          if (pe_req_op_o !== q.op || pe_req_vfu_o !== q.vfu) begin
            $display("Error at %0t: op/unit %0d/%0d, expected %0d/%0d", $time,
                     pe_req_op_o, pe_req_vfu_o, q.op, q.vfu);
            val_errs++;
          end
          if (pe_req_hazard_o !== exp_h) begin
            $display("Error at %0t: hazard %b, expected %b", $time, pe_req_hazard_o, exp_h);
            val_errs++;
          end
          record_users(q, exp_id);
          m_unit[exp_id]  = q.vfu;
          m_row[exp_id]   = exp_h;
          new_bit[exp_id] = 1'b1;
          if (q.is_mem) mem_wait = 1'b1;
          n_issued++;
        end
        hold_id  = pe_req_id_o;
        hold_op  = pe_req_op_o;
        hold_vfu = pe_req_vfu_o;
        hold_h   = pe_req_hazard_o;
      end else if (pe_req_valid_o) begin
        // Fields must not move while the PEs stall
        if (pe_req_id_o !== hold_id || pe_req_op_o !== hold_op ||
            pe_req_vfu_o !== hold_vfu || pe_req_hazard_o !== hold_h) begin
          $display("Error at %0t: PE request changed while stalled", $time);
          val_errs++;
        end
      end
      // Running set and table as the DUT holds them now
      m_run = (m_run & ~m_done) | new_bit;
      for (int r = 0; r < n_vinsn; r++) m_row[r] = m_row[r] & ~m_done;
      drop_retired(m_run);
      m_done = vinsn_done_i;
      if (idle_o !== (m_run == '0)) begin
        $display("Error at %0t: idle %b with running set %b", $time, idle_o, m_run);
        val_errs++;
      end
      for (int i = 0; i < n_vinsn; i++) begin
        if (m_run[i] && hazard_table_o[i*n_vinsn +: n_vinsn] !== m_row[i]) begin
          $display("Error at %0t: table row %0d is %b, expected %b", $time, i,
                   hazard_table_o[i*n_vinsn +: n_vinsn], m_row[i]);
          val_errs++;
        end
      end
      for (int u = 0; u < n_vfus; u++) begin
        cnt = 0;
        for (int i = 0; i < n_vinsn; i++) begin
          if (m_run[i] && m_unit[i] == vfu_e'(u)) cnt++;
        end
        if (cnt > queue_depth[u]) begin
          $display("Unit %0d holds %0d instructions at %0t, above its queue depth", u, cnt,
                   $time);
          flow_errs++;
        end
      end
      // Response is due the cycle after the ack
      if (resp_valid_o) begin
        if (!resp_due) begin
          $display("Response at %0t without a preceding address ack", $time);
          flow_errs++;
        end else if (resp_error_o !== resp_err_exp) begin
          $display("Error at %0t: response error %b, expected %b", $time, resp_error_o,
                   resp_err_exp);
          val_errs++;
        end
        mem_wait = 1'b0;
      end else if (resp_due) begin
        $display("Response missing at %0t after an address ack", $time);
        flow_errs++;
        mem_wait = 1'b0;
      end
      resp_due     = addrgen_ack_i && mem_wait;
      resp_err_exp = addrgen_error_i;
      pv_prev      = pe_req_valid_o;
      hs_prev      = pe_req_valid_o && pe_req_ready_i;
    end
  end

  //////////////////////////////
  // Reset, end and watchdog
  //////////////////////////////

  initial begin
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = vadd;
    req_vd_i        = '0;
    req_vs1_i       = '0;
    req_vs2_i       = '0;
    req_use_vd_i    = 1'b0;
    req_use_vs1_i   = 1'b0;
    req_use_vs2_i   = 1'b0;
    req_vm_i        = 1'b1;
    pe_req_ready_i  = 1'b0;
    vinsn_done_i    = '0;
    addrgen_ack_i   = 1'b0;
    addrgen_error_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (idle_o !== 1'b1 || req_ready_o !== 1'b1 || pe_req_valid_o !== 1'b0 ||
        resp_valid_o !== 1'b0 || hazard_table_o !== '0) begin
      $display("Error at %0t: outputs not in their reset state", $time);
      val_errs++;
    end
    // Run until every request is issued, finished and answered
    while (n_issued < n_tests || pend_q.size() != 0 || m_run != '0 || mem_wait) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    report_counts();
    if (val_errs == 0 && flow_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (n_tests * cycles_per_test) @(posedge clk_i);
    $display("Timeout: the sequencer did not finish all instructions in time");
    report_counts();
    $display("Verification failed");
    $finish;
  end

endmodule

//--- hw/vseq_top.sv
module vseq_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request from the scalar core
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  vseq_pkg::vop_e        req_op_i,
  input  vseq_pkg::vreg_t       req_vd_i,
  input  vseq_pkg::vreg_t       req_vs1_i,
  input  vseq_pkg::vreg_t       req_vs2_i,
  input  logic                  req_use_vd_i,
  input  logic                  req_use_vs1_i,
  input  logic                  req_use_vs2_i,
  input  logic                  req_vm_i,
  // Issue to the processing elements
  output logic                  pe_req_valid_o,
  input  logic                  pe_req_ready_i,
  output vseq_pkg::vid_t        pe_req_id_o,
  output vseq_pkg::vop_e        pe_req_op_o,
  output vseq_pkg::vfu_e        pe_req_vfu_o,
  output vseq_pkg::hazard_vec_t pe_req_hazard_o,
  input  vseq_pkg::hazard_vec_t vinsn_done_i,
  // Address generation and response
  input  logic                  addrgen_ack_i,
  input  logic                  addrgen_error_i,
  output logic                  resp_valid_o,
  output logic                  resp_error_o,
  // Status
  output logic                  idle_o,
  output logic [vseq_pkg::n_vinsn*vseq_pkg::n_vinsn-1:0] hazard_table_o
);
  import vseq_pkg::*;

  hazard_vec_t running;
  hazard_vec_t hazard;

  dec_if   dec ();
  issue_if iss ();

  vseq_decode vseq_decode_inst (
    .clk_i, .rst_ni, .req_valid_i, .req_ready_o, .req_op_i, .req_vd_i, .req_vs1_i,
    .req_vs2_i, .req_use_vd_i, .req_use_vs1_i, .req_use_vs2_i, .req_vm_i, .dec (dec)
  );

  vseq_hazard_check vseq_hazard_check_inst (
    .clk_i, .rst_ni, .dec (dec), .iss (iss), .running_i (running), .hazard_o (hazard)
  );

  vseq_issue_ctrl vseq_issue_ctrl_inst (
    .clk_i, .rst_ni, .dec (dec), .iss (iss), .hazard_i (hazard),
    .pe_req_valid_o, .pe_req_ready_i, .pe_req_id_o, .pe_req_op_o, .pe_req_vfu_o,
    .pe_req_hazard_o, .addrgen_ack_i, .addrgen_error_i, .resp_valid_o, .resp_error_o
  );

  vseq_completion vseq_completion_inst (
    .clk_i, .rst_ni, .iss (iss), .vinsn_done_i, .running_o (running), .idle_o,
    .hazard_table_o
  );

endmodule

//--- hw/vseq_completion.sv
module vseq_completion (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  issue_if.issue_dst            iss,
  input  vseq_pkg::hazard_vec_t vinsn_done_i,
  output vseq_pkg::hazard_vec_t running_o,
  output logic                  idle_o,
  output logic [vseq_pkg::n_vinsn*vseq_pkg::n_vinsn-1:0] hazard_table_o
);
  import vseq_pkg::*;

  hazard_vec_t running_q, running_d;
  // Unit each ID was issued to
  vfu_e        unit_q [n_vinsn];
  // Per-unit queue occupancy
  cnt_t        cnt_q [n_vfus];
  cnt_t        cnt_d [n_vfus];
  cnt_t        done_cnt [n_vfus];
  // Row N lists the IDs instruction N depends on
  hazard_vec_t [n_vinsn-1:0] table_q, table_d;

  assign running_o      = running_q;
  assign iss.running    = running_q;
  assign iss.full       = &running_q;
  assign idle_o         = ~|running_q;
  assign hazard_table_o = table_q;

  // Lowest free ID, scanned from the top so bit 0 wins
  always_comb begin
    iss.next_id = '0;
    for (int i = n_vinsn - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        iss.next_id = vid_t'(i);
      end
    end
  end

  //////////////////////////////
  // Queue counters
  //////////////////////////////

  always_comb begin
    for (int u = 0; u < n_vfus; u++) begin
      done_cnt[u] = '0;
      for (int i = 0; i < n_vinsn; i++) begin
        if (vinsn_done_i[i] && unit_q[i] == vfu_e'(u)) begin
          done_cnt[u] = done_cnt[u] + cnt_t'(1);
        end
      end
      // Up and down in one cycle cancel out
      cnt_d[u] = cnt_q[u] + cnt_t'(iss.fire && iss.vfu == vfu_e'(u)) - done_cnt[u];
      iss.q_free[u] = cnt_q[u] < cnt_t'(queue_depth[u]);
    end
  end

  // Running set and hazard table
  always_comb begin
    running_d = running_q & ~vinsn_done_i;
    table_d   = table_q;
    if (iss.fire) begin
      running_d[iss.id] = 1'b1;
      table_d[iss.id]   = iss.hazard;
    end
    // Finished IDs vanish from every row
    for (int r = 0; r < n_vinsn; r++) begin
      table_d[r] = table_d[r] & ~vinsn_done_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
      table_q   <= '0;
      cnt_q     <= '{default: '0};
    end else begin
      running_q <= running_d;
      table_q   <= table_d;
      cnt_q     <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (iss.fire) begin
      unit_q[iss.id] <= iss.vfu;
    end
  end

  // PEs may only retire what the sequencer issued
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (vinsn_done_i & ~running_q) == '0)
    else $error("done reported for an ID that is not running");

endmodule

//--- hw/vseq_issue_ctrl.sv
module vseq_issue_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  dec_if.dec_dst                dec,
  issue_if.issue_src            iss,
  input  vseq_pkg::hazard_vec_t hazard_i,
  // Request to the processing elements
  output logic                  pe_req_valid_o,
  input  logic                  pe_req_ready_i,
  output vseq_pkg::vid_t        pe_req_id_o,
  output vseq_pkg::vop_e        pe_req_op_o,
  output vseq_pkg::vfu_e        pe_req_vfu_o,
  output vseq_pkg::hazard_vec_t pe_req_hazard_o,
  // Address generation and core response
  input  logic                  addrgen_ack_i,
  input  logic                  addrgen_error_i,
  output logic                  resp_valid_o,
  output logic                  resp_error_o
);
  import vseq_pkg::*;

  // Set while a load or store waits for its address ack
  logic wait_q, wait_d;
  logic resp_valid_d;
  logic pe_slot_free;
  logic can_issue;

  //////////////////////////////
  // Issue gate
  //////////////////////////////

  // Output register is empty or handing off this cycle
  assign pe_slot_free = !pe_req_valid_o || pe_req_ready_i;

  // Free ID, room in the target unit queue and no memory op pending
  assign can_issue = pe_slot_free && !wait_q && !iss.full &&
                     iss.q_free[dec.insn.vfu];

  assign dec.ready  = can_issue;
  assign iss.fire   = dec.valid && can_issue;
  assign iss.id     = iss.next_id;
  assign iss.vfu    = dec.insn.vfu;
  assign iss.hazard = hazard_i;

  //////////////////////////////
  // Issue and address wait FSM
  //////////////////////////////

  always_comb begin
    wait_d       = wait_q;
    resp_valid_d = 1'b0;
    if (!wait_q) begin
      // Memory ops park the sequencer until addrgen answers
      if (iss.fire && dec.insn.is_mem) begin
        wait_d = 1'b1;
      end
    end else if (addrgen_ack_i) begin
      wait_d       = 1'b0;
      resp_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q       <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      wait_q       <= wait_d;
      resp_valid_o <= resp_valid_d;
    end
  end

  // Error flag sampled together with the ack
  always_ff @(posedge clk_i) begin
    if (resp_valid_d) begin
      resp_error_o <= addrgen_error_i;
    end
  end

  //////////////////////////////
  // PE request register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (iss.fire) begin
      pe_req_valid_o <= 1'b1;
    end else if (pe_req_ready_i) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // Fields stay frozen until the next fire
  always_ff @(posedge clk_i) begin
    if (iss.fire) begin
      pe_req_id_o     <= iss.next_id;
      pe_req_op_o     <= dec.insn.op;
      pe_req_vfu_o    <= dec.insn.vfu;
      pe_req_hazard_o <= hazard_i;
    end
  end

  // Scoreboard must offer a free ID whenever an instruction is accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    iss.fire |-> !iss.running[iss.id])
    else $error("fire with no free instruction ID");

endmodule

//--- hw/vseq_hazard_check.sv
module vseq_hazard_check (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  dec_if.dec_dst                dec,
  issue_if.issue_mon            iss,
  input  vseq_pkg::hazard_vec_t running_i,
  output vseq_pkg::hazard_vec_t hazard_o
);
  import vseq_pkg::*;

  // Last reader and last writer of every vector register
  vid_t [n_vregs-1:0] rd_id_q, rd_id_d;
  vid_t [n_vregs-1:0] wr_id_q, wr_id_d;
  logic [n_vregs-1:0] rd_vld_q, rd_vld_d;
  logic [n_vregs-1:0] wr_vld_q, wr_vld_d;

  hazard_vec_t raw, war, waw;

  //////////////////////////////
  // Hazards of the held insn
  //////////////////////////////

  always_comb begin
    raw = '0;
    war = '0;
    waw = '0;
    // RAW on each source operand
    if (dec.insn.use_vs1 && wr_vld_q[dec.insn.vs1]) begin
      raw[wr_id_q[dec.insn.vs1]] = 1'b1;
    end
    if (dec.insn.use_vs2 && wr_vld_q[dec.insn.vs2]) begin
      raw[wr_id_q[dec.insn.vs2]] = 1'b1;
    end
    // Masked ops also read v0
    if (!dec.insn.vm && wr_vld_q[vmask_reg]) begin
      raw[wr_id_q[vmask_reg]] = 1'b1;
    end
    if (dec.insn.use_vd) begin
      // WAR against the last reader of vd
      if (rd_vld_q[dec.insn.vd]) begin
        war[rd_id_q[dec.insn.vd]] = 1'b1;
      end
      // WAW against the last writer of vd
      if (wr_vld_q[dec.insn.vd]) begin
        waw[wr_id_q[dec.insn.vd]] = 1'b1;
      end
    end
    // List entries lag completion by a cycle, so filter with running
    hazard_o = dec.valid ? ((raw | war | waw) & running_i) : '0;
  end

  //////////////////////////////
  // Reader and writer lists
  //////////////////////////////

  always_comb begin
    rd_id_d = rd_id_q;
    wr_id_d = wr_id_q;
    // Drop entries whose instruction has retired
    for (int v = 0; v < n_vregs; v++) begin
      rd_vld_d[v] = rd_vld_q[v] && running_i[rd_id_q[v]];
      wr_vld_d[v] = wr_vld_q[v] && running_i[wr_id_q[v]];
    end
    // Accepted instruction becomes the newest user of its registers
    if (iss.fire) begin
      if (dec.insn.use_vd) begin
        wr_id_d[dec.insn.vd]  = iss.id;
        wr_vld_d[dec.insn.vd] = 1'b1;
      end
      if (dec.insn.use_vs1) begin
        rd_id_d[dec.insn.vs1]  = iss.id;
        rd_vld_d[dec.insn.vs1] = 1'b1;
      end
      if (dec.insn.use_vs2) begin
        rd_id_d[dec.insn.vs2]  = iss.id;
        rd_vld_d[dec.insn.vs2] = 1'b1;
      end
      if (!dec.insn.vm) begin
        rd_id_d[vmask_reg]  = iss.id;
        rd_vld_d[vmask_reg] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_id_q  <= '0;
      wr_id_q  <= '0;
      rd_vld_q <= '0;
      wr_vld_q <= '0;
    end else begin
      rd_id_q  <= rd_id_d;
      wr_id_q  <= wr_id_d;
      rd_vld_q <= rd_vld_d;
      wr_vld_q <= wr_vld_d;
    end
  end

endmodule

//--- hw/vseq_decode.sv
module vseq_decode (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  vseq_pkg::vop_e  req_op_i,
  input  vseq_pkg::vreg_t req_vd_i,
  input  vseq_pkg::vreg_t req_vs1_i,
  input  vseq_pkg::vreg_t req_vs2_i,
  input  logic            req_use_vd_i,
  input  logic            req_use_vs1_i,
  input  logic            req_use_vs2_i,
  input  logic            req_vm_i,
  dec_if.dec_src          dec
);
  import vseq_pkg::*;

  dec_insn_t insn_d;
  logic      accept;

  // Unit of an operation, taken from its range in vop_e
  function automatic vfu_e op_unit(vop_e op);
    case (op) inside
      [vadd:vand]:  op_unit = vfu_alu;
      [vmul:vmacc]: op_unit = vfu_mul;
      vle:          op_unit = vfu_load;
      vse:          op_unit = vfu_store;
      default:      op_unit = vfu_alu;
    endcase
  endfunction

  // Stage is free when empty or handing off this cycle
  assign req_ready_o = !dec.valid || dec.ready;
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    insn_d.op      = req_op_i;
    insn_d.vfu     = op_unit(req_op_i);
    // Loads and stores wait for address generation later
    insn_d.is_mem  = (insn_d.vfu == vfu_load) || (insn_d.vfu == vfu_store);
    insn_d.vs1     = req_vs1_i;
    insn_d.use_vs1 = req_use_vs1_i;
    insn_d.vs2     = req_vs2_i;
    insn_d.use_vs2 = req_use_vs2_i;
    insn_d.vd      = req_vd_i;
    insn_d.use_vd  = req_use_vd_i;
    insn_d.vm      = req_vm_i;
  end

  //////////////////////////////
  // One-entry holding register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec.valid <= 1'b0;
    end else if (accept) begin
      dec.valid <= 1'b1;
    end else if (dec.ready) begin
      dec.valid <= 1'b0;
    end
  end

  // Payload only moves on a new request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec.insn <= insn_d;
    end
  end

  // Held instruction stays put until issue takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec.valid && !dec.ready |=> dec.valid && $stable(dec.insn))
    else $error("decoded instruction dropped or changed before transfer");

endmodule

//--- hw/vseq_if.sv
// Decoded instruction from decode to issue, valid/ready
interface dec_if;
  import vseq_pkg::*;

  logic      valid;
  logic      ready;
  dec_insn_t insn;

  // Producer side
  modport dec_src (output valid, output insn, input ready);
  // Consumer side, also used by the hazard check as a monitor
  modport dec_dst (input valid, input insn, output ready);
endinterface

// Issue events toward the scoreboard and status back from it
interface issue_if;
  import vseq_pkg::*;

  logic        fire;
  vid_t        id;
  vfu_e        vfu;
  hazard_vec_t hazard;
  hazard_vec_t running;
  logic        full;
  vid_t        next_id;
  logic [n_vfus-1:0] q_free;

  modport issue_src (output fire, id, vfu, hazard, input running, full, next_id, q_free);
  modport issue_dst (input fire, id, vfu, hazard, output running, full, next_id, q_free);
  // Observer of accepted instructions
  modport issue_mon (input fire, id);
endinterface

//--- hw/vseq_pkg.sv
package vseq_pkg;

  //////////////////////////////
  // Instruction IDs and registers
  //////////////////////////////

  // Instructions in flight at once
  localparam int unsigned n_vinsn = 8;
  typedef logic [2:0] vid_t;

  // Architectural vector registers
  localparam int unsigned n_vregs = 32;
  typedef logic [4:0] vreg_t;

  // v0 holds the mask for masked operations
  localparam vreg_t vmask_reg = 5'd0;

  //////////////////////////////
  // Units and operations
  //////////////////////////////

  typedef enum logic [1:0] {vfu_alu, vfu_mul, vfu_load, vfu_store} vfu_e;
  localparam int unsigned n_vfus = 4;

  // Grouped in contiguous ranges per unit, decode relies on this order
  typedef enum logic [2:0] {vadd, vsub, vand, vmul, vmacc, vle, vse} vop_e;

  // Instruction queue depth of each unit, indexed by vfu_e
  localparam int unsigned queue_depth [n_vfus] = '{4, 3, 2, 2};

  // Wide enough to hold the deepest queue count
  typedef logic [2:0] cnt_t;

  // One bit per instruction ID
  typedef logic [n_vinsn-1:0] hazard_vec_t;

  // Decoded instruction as handed from decode to issue
  typedef struct packed {
    vop_e  op;
    vfu_e  vfu;
    logic  is_mem;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
    logic  vm;      // 1 = unmasked
  } dec_insn_t;

endpackage
